//--- verif/matmul_testdata.txt
# W row w0 w1 w2 w3                  weight wj goes to column j of that row
# V addr mode mask(hex) a0 a1 a2 a3  mode 1 adds, 0 overwrites
# D                                  wait until busy_o is low
# R addr e0 e1 e2 e3                 expected column sums, signed decimal
W 0 1 2 3 4
W 1 -1 0 1 2
W 2 2 -2 0 1
W 3 0 1 -1 3
# overwrite
V 0 0 f 1 2 3 4
D
R 0 5 0 1 23
# add onto the same row
V 0 1 f -3 5 0 7
D
R 0 -3 1 -10 42
# masked writes, clear columns keep their sums
V 0 0 5 2 2 2 2
V 0 1 a 1 1 1 1
D
R 0 4 2 6 52
# pipelined vectors with signed extremes
V 1 0 f 127 127 127 127
V 2 0 f -128 -128 -128 -128
V 3 0 f -128 127 -128 127
V 4 0 f 10 -20 30 -40
V 5 0 f 0 0 0 -1
V 1 1 f 127 127 127 127
D
R 1 508 254 762 2540
R 2 -256 -128 -384 -1280
R 3 -511 127 -384 -5
R 4 90 -80 50 -90
R 5 0 -1 1 -3
# new weights, older rows stay as they were
W 0 -128 127 0 1
W 1 127 -128 1 0
W 2 1 1 1 1
W 3 -1 -1 -1 -1
V 6 0 f 1 2 3 4
V 7 0 f -128 -128 127 127
V 4 1 f 1 1 1 1
D
R 6 125 -130 1 0
R 7 128 128 -128 -128
R 4 89 -81 51 -89
R 0 4 2 6 52
R 2 -256 -128 -384 -1280

//--- sim.f
design/tpu_pkg.sv
design/mac_cell.sv
design/input_skew.sv
design/systolic_array.sv
design/accumulator.sv
design/matmul_unit.sv
verif/matmul_checker.sv
verif/tb_matmul_unit.sv

//--- Makefile
TOP := tb_matmul_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module matmul_unit

clean:
	rm -rf obj_dir

//--- verif/tb_matmul_unit.sv
`timescale 1ns/1ps

module tb_matmul_unit;

    localparam int VEC_W = tpu_pkg::ARR_N * tpu_pkg::DATA_W;
    localparam int ROW_SUM_W = tpu_pkg::ARR_N * tpu_pkg::ACC_W;
    localparam int ARGS = 7;  // slots per parsed command

    logic                       clk_i;
    logic                       rst_i;
    logic                       w_wr_i;
    logic [tpu_pkg::ROW_W-1:0]  w_row_i;
    logic [VEC_W-1:0]           w_data_i;
    logic                       vec_valid_i;
    logic [VEC_W-1:0]           vec_i;
    logic [tpu_pkg::ADDR_W-1:0] acc_addr_i;
    logic                       acc_mode_i;
    logic [tpu_pkg::ARR_N-1:0]  col_mask_i;
    logic                       rd_en_i;
    logic [tpu_pkg::ADDR_W-1:0] rd_addr_i;
    logic [ROW_SUM_W-1:0]       rd_data_o;
    logic                       rd_valid_o;
    logic                       busy_o;

    logic [ROW_SUM_W-1:0] exp_row;
    int                   test_num;
    int                   err_cnt;
    int                   test_cnt;

    logic [7:0]  kind_q [$];
    int          arg_q  [$];  // ARGS ints per command
    int          n_lines    = 0;
    int          n_reads    = 0;
    int          parse_errs = 0;
    logic        parse_done = 1'b0;
    logic [31:0] lcg_state  = 32'h18cb819b;

    matmul_unit matmul_unit_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .w_wr_i      (w_wr_i),
        .w_row_i     (w_row_i),
        .w_data_i    (w_data_i),
        .vec_valid_i (vec_valid_i),
        .vec_i       (vec_i),
        .acc_addr_i  (acc_addr_i),
        .acc_mode_i  (acc_mode_i),
        .col_mask_i  (col_mask_i),
        .rd_en_i     (rd_en_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .rd_valid_o  (rd_valid_o),
        .busy_o      (busy_o)
    );

    matmul_checker checker_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .vec_valid_i (vec_valid_i),
        .rd_en_i     (rd_en_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_i   (rd_data_o),
        .rd_valid_i  (rd_valid_o),
        .busy_i      (busy_o),
        .exp_row_i   (exp_row),
        .test_num_i  (test_num),
        .err_cnt_o   (err_cnt),
        .test_cnt_o  (test_cnt)
    );

    always #4 clk_i = ~clk_i;  // 8 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [VEC_W-1:0] pack_elems(input int base);
        logic [VEC_W-1:0] v;
        for (int k = 0; k < tpu_pkg::ARR_N; k++) begin
            v[k*tpu_pkg::DATA_W +: tpu_pkg::DATA_W] = tpu_pkg::DATA_W'(arg_q[base + k]);
        end
        return v;
    endfunction

    function automatic logic [ROW_SUM_W-1:0] pack_sums(input int base);
        logic [ROW_SUM_W-1:0] v;
        for (int k = 0; k < tpu_pkg::ARR_N; k++) begin
            v[k*tpu_pkg::ACC_W +: tpu_pkg::ACC_W] = tpu_pkg::ACC_W'(arg_q[base + k]);
        end
        return v;
    endfunction

    task automatic read_commands();
        int         fd;
        int         got;
        int         want;
        int         c;
        logic [7:0] ch;
        int         a [ARGS];
        fd = $fopen("verif/matmul_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/matmul_testdata.txt");
            parse_errs++;
            return;
        end
        got = $fscanf(fd, " %c", ch);
        while (got == 1) begin
            n_lines++;
            for (int k = 0; k < ARGS; k++) begin
                a[k] = 0;
            end
            if (ch == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);  // rest of the comment
                end
            end else begin
                case (ch)
                    "W": begin
                        want = 5;
                        got  = $fscanf(fd, "%d %d %d %d %d", a[0], a[1], a[2], a[3], a[4]);
                    end
                    "V": begin
                        want = 7;
                        got  = $fscanf(fd, "%d %d %h %d %d %d %d",
                                       a[0], a[1], a[2], a[3], a[4], a[5], a[6]);
                    end
                    "R": begin
                        want = 5;
                        got  = $fscanf(fd, "%d %d %d %d %d", a[0], a[1], a[2], a[3], a[4]);
                    end
                    "D": begin
                        want = 0;
                        got  = 0;
                    end
                    default: begin
                        want = -1;
                        got  = 0;
                    end
                endcase
                if (got != want) begin
                    $display("bad command %s on data line %0d", ch, n_lines);
                    parse_errs++;
                end else begin
                    kind_q.push_back(ch);
                    for (int k = 0; k < ARGS; k++) begin
                        arg_q.push_back(a[k]);
                    end
                end
            end
            got = $fscanf(fd, " %c", ch);
        end
        $fclose(fd);
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        w_wr_i      <= 1'b0;
        vec_valid_i <= 1'b0;
        rd_en_i     <= 1'b0;
    endtask

    task automatic load_weight_row(input int base);
        @(posedge clk_i);
        w_wr_i      <= 1'b1;
        w_row_i     <= tpu_pkg::ROW_W'(arg_q[base]);
        w_data_i    <= pack_elems(base + 1);
        vec_valid_i <= 1'b0;
        rd_en_i     <= 1'b0;
    endtask

    task automatic send_vector(input int base);
        @(posedge clk_i);
        w_wr_i      <= 1'b0;
        vec_valid_i <= 1'b1;
        acc_addr_i  <= tpu_pkg::ADDR_W'(arg_q[base]);
        acc_mode_i  <= (arg_q[base + 1] != 0);
        col_mask_i  <= tpu_pkg::ARR_N'(arg_q[base + 2]);
        vec_i       <= pack_elems(base + 3);
        rd_en_i     <= 1'b0;
    endtask

    task automatic issue_read(input int base, input int num);
        @(posedge clk_i);
        w_wr_i      <= 1'b0;
        vec_valid_i <= 1'b0;
        rd_en_i     <= 1'b1;
        rd_addr_i   <= tpu_pkg::ADDR_W'(arg_q[base]);
        exp_row     <= pack_sums(base + 1);
        test_num    <= num;
    endtask

    // the first edge takes the last strobe and busy_o is polled mid cycle
    task automatic wait_drain();
        idle_cycle();
        @(negedge clk_i);
        while (busy_o) begin
            idle_cycle();
            @(negedge clk_i);
        end
    endtask

    initial begin : watchdog
        wait (parse_done);
        #(((n_lines * (tpu_pkg::CTRL_DEPTH + 8)) + 8) * 8);  // plus reset cycles
        $display("watchdog expired after %0d data lines worth of cycles", n_lines);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        int         base;
        logic       gapped;
        logic [7:0] prev_kind;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        w_wr_i      = 1'b0;
        w_row_i     = '0;
        w_data_i    = '0;
        vec_valid_i = 1'b0;
        vec_i       = '0;
        acc_addr_i  = '0;
        acc_mode_i  = 1'b0;
        col_mask_i  = '0;
        rd_en_i     = 1'b0;
        rd_addr_i   = '0;
        exp_row     = '0;
        test_num    = 0;
        gapped      = 1'b0;
        prev_kind   = 8'h00;

        read_commands();
        parse_done = 1'b1;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int i = 0; i < kind_q.size(); i++) begin
            base = i * ARGS;
            case (kind_q[i])
                "W": load_weight_row(base);
                "V": begin
                    lcg_state = lcg_next(lcg_state);
                    if (prev_kind != "V") begin
                        gapped = lcg_state[31];  // a new run is either back to back or gapped
                    end else if (gapped) begin
                        repeat (int'(lcg_state[31:30])) idle_cycle();
                    end
                    send_vector(base);
                end
                "D": wait_drain();
                "R": begin
                    n_reads++;
                    issue_read(base, n_reads);
                end
                default: ;
            endcase
            prev_kind = kind_q[i];
        end
        wait_drain();
        repeat (2) idle_cycle();
        @(posedge clk_i);  // the checker's last negedge has passed

        $display("reads checked %0d of %0d, errors %0d, data file errors %0d",
                 test_cnt, n_reads, err_cnt, parse_errs);
        if (test_cnt != n_reads) begin
            $display("checker saw a different number of reads than were issued");
        end
        if (parse_errs == 0 && err_cnt == 0 && test_cnt == n_reads && n_reads > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verif/matmul_checker.sv
`timescale 1ns/1ps

module matmul_checker (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  logic                                     vec_valid_i,
    input  logic                                     rd_en_i,
    input  logic [tpu_pkg::ADDR_W-1:0]               rd_addr_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0] rd_data_i,
    input  logic                                     rd_valid_i,
    input  logic                                     busy_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0] exp_row_i,
    input  int                                       test_num_i,
    output int                                       err_cnt_o,
    output int                                       test_cnt_o
);

    // read seen on the previous negedge and still waiting for its data
    logic                                     pend        = 1'b0;
    logic [tpu_pkg::ADDR_W-1:0]               pend_addr   = '0;
    logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0] pend_exp    = '0;
    int                                       pend_num    = 0;
    int                                       errors      = 0;
    int                                       tests       = 0;
    logic                                     rst_flagged = 1'b0;
    // strobes taken by the last CTRL_DEPTH edges, newest in bit 0
    logic [tpu_pkg::CTRL_DEPTH-1:0]           strobe_hist = '0;

    assign err_cnt_o  = errors;
    assign test_cnt_o = tests;

    task automatic compare_row();
        logic [tpu_pkg::ACC_W-1:0] got;
        logic [tpu_pkg::ACC_W-1:0] want;
        int                        bad;
        bad = 0;
        if (rd_valid_i !== 1'b1) begin
            $display("test %0d: rd_valid_o did not pulse one cycle after rd_en_i (time %0t)",
                     pend_num, $time);
            bad = 1;
        end else begin
            for (int j = 0; j < tpu_pkg::ARR_N; j++) begin
                got  = rd_data_i[j*tpu_pkg::ACC_W +: tpu_pkg::ACC_W];
                want = pend_exp[j*tpu_pkg::ACC_W +: tpu_pkg::ACC_W];
                if (got !== want) begin
                    $display("Error: time %0t, rd_data_o[%0d] = %0d, expected %0d",
                             $time, j, $signed(got), $signed(want));
                    bad++;
                end
            end
        end
        errors += bad;
        tests++;
        $display("test %0d: read row %0d %s", pend_num, pend_addr,
                 (bad == 0) ? "passed" : "failed");
    endtask

    // sample mid cycle where DUT outputs and driven inputs are settled
    always @(negedge clk_i) begin
        if (rst_i) begin
            pend        = 1'b0;
            strobe_hist = '0;
            if ((busy_i !== 1'b0 || rd_valid_i !== 1'b0) && !rst_flagged) begin
                $display("busy_o or rd_valid_o is not low during reset (time %0t)", $time);
                errors++;
                rst_flagged = 1'b1;
            end
        end else begin
            if (pend) begin
                compare_row();
            end else if (rd_valid_i !== 1'b0) begin
                $display("rd_valid_o pulsed with no read request (time %0t)", $time);
                errors++;
            end
            // each strobe holds busy_o high until its last column has stored
            if (busy_i !== (|strobe_hist)) begin
                $display("Error: time %0t, busy_o = %0b, expected %0b",
                         $time, busy_i, |strobe_hist);
                errors++;
            end
            strobe_hist = {strobe_hist[tpu_pkg::CTRL_DEPTH-2:0], (vec_valid_i === 1'b1)};
            pend      = (rd_en_i === 1'b1);
            pend_addr = rd_addr_i;
            pend_exp  = exp_row_i;
            pend_num  = test_num_i;
        end
    end

endmodule

//--- design/matmul_unit.sv
`timescale 1ns/1ps

module matmul_unit (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    // weight load, one grid row per strobe
    input  logic                                      w_wr_i,
    input  logic [tpu_pkg::ROW_W-1:0]                 w_row_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::DATA_W-1:0] w_data_i,
    // activation vector and its accumulator control
    input  logic                                      vec_valid_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::DATA_W-1:0] vec_i,
    input  logic [tpu_pkg::ADDR_W-1:0]                acc_addr_i,
    input  logic                                      acc_mode_i,
    input  logic [tpu_pkg::ARR_N-1:0]                 col_mask_i,
    // row read port
    input  logic                                      rd_en_i,
    input  logic [tpu_pkg::ADDR_W-1:0]                rd_addr_i,
    output logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0]  rd_data_o,
    output logic                                      rd_valid_o,
    output logic                                      busy_o
);

    logic [tpu_pkg::ARR_N*tpu_pkg::DATA_W-1:0] skew_act;  // diagonal wavefront
    logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0]  col_sum;   // bottom of each column

    input_skew input_skew_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (vec_valid_i),
        .vec_i   (vec_i),
        .act_o   (skew_act)
    );

    systolic_array systolic_array_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .w_wr_i   (w_wr_i),
        .w_row_i  (w_row_i),
        .w_data_i (w_data_i),
        .act_i    (skew_act),
        .sum_o    (col_sum)
    );

    // control enters unskewed, the delay line lines it up per column
    accumulator accumulator_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (vec_valid_i),
        .addr_i     (acc_addr_i),
        .mode_i     (acc_mode_i),
        .mask_i     (col_mask_i),
        .sum_i      (col_sum),
        .rd_en_i    (rd_en_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o),
        .busy_o     (busy_o)
    );

endmodule

//--- design/accumulator.sv
`timescale 1ns/1ps

module accumulator (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  logic                                     valid_i,
    input  logic [tpu_pkg::ADDR_W-1:0]               addr_i,
    input  logic                                     mode_i,   // 1 add, 0 overwrite
    input  logic [tpu_pkg::ARR_N-1:0]                mask_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0] sum_i,
    input  logic                                     rd_en_i,
    input  logic [tpu_pkg::ADDR_W-1:0]               rd_addr_i,
    output logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0] rd_data_o,
    output logic                                     rd_valid_o,
    output logic                                     busy_o
);

    // control delay line, stage s holds a vector s+1 cycles after sampling
    logic [tpu_pkg::CTRL_DEPTH-1:0] valid_q;
    logic [tpu_pkg::ADDR_W-1:0]     addr_q [tpu_pkg::CTRL_DEPTH];
    logic [tpu_pkg::CTRL_DEPTH-1:0] mode_q;
    logic [tpu_pkg::ARR_N-1:0]      mask_q [tpu_pkg::CTRL_DEPTH];

    logic rd_hazard;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            mode_q  <= '0;
            addr_q  <= '{default: '0};
            mask_q  <= '{default: '0};
        end else begin
            valid_q <= {valid_q[tpu_pkg::CTRL_DEPTH-2:0], valid_i};
            mode_q  <= {mode_q[tpu_pkg::CTRL_DEPTH-2:0], mode_i};
            addr_q[0] <= addr_i;
            mask_q[0] <= mask_i;
            for (int s = 1; s < tpu_pkg::CTRL_DEPTH; s++) begin
                addr_q[s] <= addr_q[s-1];
                mask_q[s] <= mask_q[s-1];
            end
        end
    end

    assign busy_o = |valid_q;  // something still in flight

    // one bank per column, each tapping the delay line one stage later
    for (genvar j = 0; j < tpu_pkg::ARR_N; j++) begin : g_bank
        logic [tpu_pkg::ACC_W-1:0]  bank [tpu_pkg::ACC_DEPTH];
        logic [tpu_pkg::ACC_W-1:0]  rd_word;
        logic [tpu_pkg::ACC_W-1:0]  col_sum;
        logic [tpu_pkg::ACC_W-1:0]  base;
        logic [tpu_pkg::ADDR_W-1:0] wr_addr;
        logic                       wr_en;

        // column j sum sits at the grid bottom while this stage is current
        assign wr_addr = addr_q[tpu_pkg::ARRAY_LAT + j - 1];
        assign wr_en   = valid_q[tpu_pkg::ARRAY_LAT + j - 1] &&
                         mask_q[tpu_pkg::ARRAY_LAT + j - 1][j];
        assign base    = mode_q[tpu_pkg::ARRAY_LAT + j - 1] ? bank[wr_addr] : '0;
        assign col_sum = sum_i[j*tpu_pkg::ACC_W +: tpu_pkg::ACC_W];

        always_ff @(posedge clk_i) begin
            if (wr_en) begin
                bank[wr_addr] <= base + col_sum;  // wraps mod 2**32
            end
        end

        always_ff @(posedge clk_i) begin
            if (rd_en_i) begin
                rd_word <= bank[rd_addr_i];
            end
        end

        assign rd_data_o[j*tpu_pkg::ACC_W +: tpu_pkg::ACC_W] = rd_word;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;  // single cycle pulse per request
        end
    end

    // does any in-flight vector still target the row being read
    always_comb begin
        rd_hazard = 1'b0;
        for (int s = 0; s < tpu_pkg::CTRL_DEPTH; s++) begin
            if (valid_q[s] && (addr_q[s] == rd_addr_i)) begin
                rd_hazard = 1'b1;
            end
        end
    end

    // reading a row before its pending columns have landed returns stale sums
    a_rd_in_flight : assert property (
        @(posedge clk_i) disable iff (rst_i) rd_en_i |-> !rd_hazard
    ) else $error("accumulator: read of row %0d while a vector is in flight", rd_addr_i);

endmodule

//--- design/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      w_wr_i,
    input  logic [tpu_pkg::ROW_W-1:0]                 w_row_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::DATA_W-1:0] w_data_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::DATA_W-1:0] act_i,
    output logic [tpu_pkg::ARR_N*tpu_pkg::ACC_W-1:0]  sum_o
);

    logic [tpu_pkg::ARR_N-1:0]  row_load;                                   // one strobe per row
    logic [tpu_pkg::DATA_W-1:0] act_h  [tpu_pkg::ARR_N][tpu_pkg::ARR_N];    // into cell (k,j)
    logic [tpu_pkg::ACC_W-1:0]  psum_v [tpu_pkg::ARR_N+1][tpu_pkg::ARR_N];  // above row k

    for (genvar k = 0; k < tpu_pkg::ARR_N; k++) begin : g_row
        assign row_load[k] = w_wr_i && (w_row_i == tpu_pkg::ROW_W'(k));
        assign act_h[k][0] = act_i[k*tpu_pkg::DATA_W +: tpu_pkg::DATA_W];  // left edge

        for (genvar j = 0; j < tpu_pkg::ARR_N; j++) begin : g_col
            if (j < tpu_pkg::ARR_N - 1) begin : g_inner
                mac_cell mac_cell_inst (
                    .clk_i    (clk_i),
                    .rst_i    (rst_i),
                    .w_load_i (row_load[k]),
                    .w_i      (w_data_i[j*tpu_pkg::DATA_W +: tpu_pkg::DATA_W]),
                    .act_i    (act_h[k][j]),
                    .psum_i   (psum_v[k][j]),
                    .act_o    (act_h[k][j+1]),
                    .psum_o   (psum_v[k+1][j])
                );
            end else begin : g_edge
                // rightmost cell, activation leaves the grid here
                mac_cell mac_cell_inst (
                    .clk_i    (clk_i),
                    .rst_i    (rst_i),
                    .w_load_i (row_load[k]),
                    .w_i      (w_data_i[j*tpu_pkg::DATA_W +: tpu_pkg::DATA_W]),
                    .act_i    (act_h[k][j]),
                    .psum_i   (psum_v[k][j]),
                    .act_o    (),
                    .psum_o   (psum_v[k+1][j])
                );
            end
        end
    end

    for (genvar j = 0; j < tpu_pkg::ARR_N; j++) begin : g_sum
        assign psum_v[0][j] = '0;                     // sums start at zero on top
        assign sum_o[j*tpu_pkg::ACC_W +: tpu_pkg::ACC_W] = psum_v[tpu_pkg::ARR_N][j];
    end

endmodule

//--- design/input_skew.sv
`timescale 1ns/1ps

module input_skew (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      valid_i,
    input  logic [tpu_pkg::ARR_N*tpu_pkg::DATA_W-1:0] vec_i,
    output logic [tpu_pkg::ARR_N*tpu_pkg::DATA_W-1:0] act_o
);

    // lane k is a chain of k+1 registers, giving the diagonal wavefront
    for (genvar k = 0; k < tpu_pkg::ARR_N; k++) begin : g_lane
        logic [tpu_pkg::DATA_W-1:0] chain [k+1];
        logic [tpu_pkg::DATA_W-1:0] elem_in;

        // idle cycles feed zeros so they add nothing downstream
        assign elem_in = valid_i ? vec_i[k*tpu_pkg::DATA_W +: tpu_pkg::DATA_W] : '0;

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                chain <= '{default: '0};
            end else begin
                chain[0] <= elem_in;
                for (int d = 1; d <= k; d++) begin
                    chain[d] <= chain[d-1];
                end
            end
        end

        assign act_o[k*tpu_pkg::DATA_W +: tpu_pkg::DATA_W] = chain[k];
    end

    a_valid_known : assert property (
        @(posedge clk_i) disable iff (rst_i) !$isunknown(valid_i)
    ) else $error("input_skew: valid_i unknown");

endmodule

//--- design/mac_cell.sv
`timescale 1ns/1ps

module mac_cell (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             w_load_i,
    input  logic [tpu_pkg::DATA_W-1:0]       w_i,
    input  logic [tpu_pkg::DATA_W-1:0]       act_i,
    input  logic [tpu_pkg::ACC_W-1:0]        psum_i,
    output logic [tpu_pkg::DATA_W-1:0]       act_o,
    output logic [tpu_pkg::ACC_W-1:0]        psum_o
);

    logic [tpu_pkg::DATA_W-1:0]   w_q;        // stationary weight
    logic signed [2*tpu_pkg::DATA_W-1:0] prod;
    logic [tpu_pkg::ACC_W-1:0]    prod_ext;

    // weight holds until the next load of this row
    always_ff @(posedge clk_i) begin
        if (w_load_i) begin
            w_q <= w_i;
        end
    end

    assign prod     = $signed(w_q) * $signed(act_i);
    assign prod_ext = {{(tpu_pkg::ACC_W - 2*tpu_pkg::DATA_W){prod[2*tpu_pkg::DATA_W-1]}}, prod};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            act_o  <= '0;
            psum_o <= '0;
        end else begin
            act_o  <= act_i;             // pass right
            psum_o <= psum_i + prod_ext; // pass down, wraps
        end
    end

    // a stray X on the load strobe would corrupt the stationary weight
    a_w_load_known : assert property (
        @(posedge clk_i) disable iff (rst_i) !$isunknown(w_load_i)
    ) else $error("mac_cell: w_load_i unknown");

endmodule

//--- design/tpu_pkg.sv
package tpu_pkg;

    // grid geometry
    localparam int ARR_N = 4;                  // rows and columns of the array
    localparam int ROW_W = $clog2(ARR_N);      // weight row select width

    // datapath widths
    localparam int DATA_W = 8;                 // signed activation / weight element
    localparam int ACC_W  = 32;                // signed partial sum, wraps mod 2**32

    // accumulator storage
    localparam int ACC_DEPTH = 16;
    localparam int ADDR_W    = $clog2(ACC_DEPTH);

    // pipeline latencies, counted from the cycle the vector strobe is driven
    // one skew register stage plus one cell register per grid row
    localparam int ARRAY_LAT = ARR_N + 1;

    // control delay line must reach the last column's write stage
    localparam int CTRL_DEPTH = ARRAY_LAT + ARR_N - 1;

endpackage
